// File: project.f
conv_pkg.sv
row_fetcher.sv
row_regs.sv
window_conv.sv
line_conv_top.sv
tb_line_conv_assertions.sv
tb_line_conv.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_line_conv
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: tb_line_conv.sv
`default_nettype none

module tb_line_conv;
    import conv_pkg::*;

    localparam int pix_per_word  = 32;
    localparam int regs_per_bank = 34;
    localparam int frame_timeout = 2000;

    logic                                  clk;
    logic                                  reset;
    logic                                  start;
    frame_cfg_t                            cfg;
    kernel_t                               kernel;
    pixel_t [2:0][pix_per_word-1:0]        rd_pixels;
    mem_req_t                              rd_req;
    conv_result_t                          result;
    logic                                  result_valid;
    logic                                  frame_done;
    logic                                  busy;

    integer       seed = 27769;
    pixel_t       img [0:63][0:31];
    kernel_t      kern_v;
    int           cur_w;
    int           cur_h;
    mem_req_t     req_seen;
    conv_result_t exp_q [$];
    bit           exp_last_q [$];
    conv_result_t exp_r;
    bit           exp_l;
    int           checked;
    int           value_errors;
    int           other_errors;
    int           done_count;
    int           frames_run;
    bit           ok;

    line_conv_top #(
        .pixels_in_word (pix_per_word),
        .shift_regs_num (regs_per_bank)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cfg          (cfg),
        .kernel       (kernel),
        .rd_pixels    (rd_pixels),
        .rd_req       (rd_req),
        .result       (result),
        .result_valid (result_valid),
        .frame_done   (frame_done),
        .busy         (busy)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // same-size output, zero outside the image
    function automatic conv_result_t ref_conv(input int row, input int col);
        conv_result_t res;
        int           acc;
        int           pr;
        int           pc;
        acc = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                pr = row + dr;
                pc = col + dc;
                if (pr >= 0 && pr < cur_h && pc >= 0 && pc < cur_w) begin
                    acc += int'(img[pr][pc]) * int'(kern_v[(dr + 1) * 3 + dc + 1]);
                end
            end
        end
        res.row = 16'(row);
        res.col = 6'(col);
        res.sum = acc_t'(acc);
        return res;
    endfunction

    // junk beyond the image, so masking in the banks gets exercised
    function automatic pixel_t word_fill(input logic [15:0] addr, input int col);
        return pixel_t'(addr[15:8] ^ addr[7:0] ^ 8'(col * 29) ^ 8'ha5);
    endfunction

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        req_seen = rd_req;
    end

    always @(posedge clk) begin : mem_model
        int a;
        #1;
        for (int r = 0; r < 3; r++) begin
            a = int'(req_seen.row_addr[r]);
            for (int j = 0; j < pix_per_word; j++) begin
                if (!req_seen.en) begin
                    rd_pixels[r][j] = '0;
                end else if (a < cur_h && j < cur_w) begin
                    rd_pixels[r][j] = img[a][j];
                end else begin
                    rd_pixels[r][j] = word_fill(req_seen.row_addr[r], j);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic check_result(input string name, input conv_result_t got,
                                input conv_result_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got row %0d col %0d sum %0d, expected row %0d col %0d sum %0d",
                     $time, name, got.row, got.col, got.sum, exp.row, exp.col, exp.sum);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("unexpected result at time %0t with no result pending", $time);
            end else begin
                exp_r = exp_q.pop_front();
                exp_l = exp_last_q.pop_front();
                check_result("result", result, exp_r);
                check_flag("frame_done", frame_done, exp_l);
                checked++;
            end
        end else if (!reset && frame_done) begin
            check_flag("frame_done", frame_done, 1'b0);
        end
        if (!reset && frame_done) begin
            done_count++;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic check_idle();
        check_flag("result_valid", result_valid, 1'b0);
        check_flag("frame_done", frame_done, 1'b0);
        check_flag("rd_req.en", rd_req.en, 1'b0);
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic prepare_frame(input int w, input int h, input bit centre_only);
        cur_w = w;
        cur_h = h;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                img[r][c] = pixel_t'($random(seed));
            end
        end
        kern_v = '0;
        if (centre_only) begin
            kern_v[4] = weight_t'(1);
        end else begin
            for (int i = 0; i < 9; i++) begin
                kern_v[i] = weight_t'($random(seed));
            end
        end
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                exp_q.push_back(ref_conv(r, c));
                exp_last_q.push_back(r == h - 1 && c == w - 1);
            end
        end
        frames_run++;
    endtask

    // first read one cycle after start
    task automatic start_frame();
        @(posedge clk);
        #1;
        cfg.img_width  = 6'(cur_w);
        cfg.img_height = 16'(cur_h);
        kernel         = kern_v;
        start          = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b1);
        check_flag("rd_req.en", rd_req.en, 1'b1);
    endtask

    task automatic wait_frame_done(output bit done);
        int cycles;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < frame_timeout) begin
            @(negedge clk);
            if (frame_done) begin
                done = 1'b1;
            end
            cycles++;
        end
        if (!done) begin
            other_errors++;
            $display("timeout: frame_done did not arrive within %0d cycles", frame_timeout);
        end
    endtask

    task automatic run_frame(input int w, input int h, input bit centre_only,
                             input bit restart, output bit done);
        prepare_frame(w, h, centre_only);
        start_frame();
        if (restart) begin
            repeat (6) @(posedge clk);
            #1;
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            @(negedge clk);
            check_flag("busy", busy, 1'b1);
        end
        wait_frame_done(done);
    endtask

    task automatic finish_run();
        $display("results checked %0d, value errors %0d, other errors %0d",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        cfg       = '0;
        kernel    = '0;
        rd_pixels = '0;
        req_seen  = '0;
        cur_w     = 0;
        cur_h     = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        run_frame(32, 5, 1'b0, 1'b0, ok);
        // back-to-back frame, start lands the cycle after frame_done
        if (ok) begin
            run_frame(3, 1, 1'b0, 1'b0, ok);
        end
        if (ok) begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            run_frame(8, 4, 1'b1, 1'b0, ok);
        end
        if (ok) begin
            run_frame(16, 6, 1'b0, 1'b1, ok);
        end
        if (ok) begin
            repeat (5) begin
                @(negedge clk);
                check_idle();
            end
            if (exp_q.size() != 0) begin
                other_errors++;
                $display("%0d expected results never arrived", exp_q.size());
            end
            if (done_count != frames_run) begin
                value_errors++;
                $display("error at %0t: frame_done count got %0d, expected %0d",
                         $time, done_count, frames_run);
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: tb_line_conv_assertions.sv
`default_nettype none

module line_conv_assertions (
    input logic               clk,
    input logic               reset,
    input logic               result_valid,
    input logic               frame_done,
    input logic               busy,
    input conv_pkg::mem_req_t rd_req
);

    //////////////////////////////////////////////////
    // pulse and ordering rules
    //////////////////////////////////////////////////

    frame_done_one_cycle: assert property (
        @(posedge clk) disable iff (reset) frame_done |=> !frame_done
    ) else $error("frame_done held for more than one cycle");

    // busy drops only after the last result
    result_only_when_busy: assert property (
        @(posedge clk) disable iff (reset) result_valid |-> busy
    ) else $error("result_valid while busy is low");

    read_only_when_busy: assert property (
        @(posedge clk) disable iff (reset) rd_req.en |-> busy
    ) else $error("rd_req.en while busy is low");

endmodule

bind line_conv_top line_conv_assertions assert_i (
    .clk          (clk),
    .reset        (reset),
    .result_valid (result_valid),
    .frame_done   (frame_done),
    .busy         (busy),
    .rd_req       (rd_req)
);

`default_nettype wire

// File: line_conv_top.sv
`default_nettype none

module line_conv_top #(
    parameter int pixels_in_word = 32,
    parameter int shift_regs_num = 34
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        start,
    input  conv_pkg::frame_cfg_t                        cfg,
    input  conv_pkg::kernel_t                           kernel,
    input  conv_pkg::pixel_t [2:0][pixels_in_word-1:0]  rd_pixels,
    output conv_pkg::mem_req_t                          rd_req,
    output conv_pkg::conv_result_t                      result,
    output logic                                        result_valid,
    output logic                                        frame_done,
    output logic                                        busy
);
    import conv_pkg::*;

    fill_cmd_t                   fill_cmd;
    logic                        fill_strobe;
    pixel_t [shift_regs_num-1:0] row_bank_1;
    pixel_t [shift_regs_num-1:0] row_bank_2;
    pixel_t [shift_regs_num-1:0] row_bank_3;
    logic                        shift_start;
    row_tag_t                    row_tag;
    logic                        conv_ready;

    row_fetcher #(
        .pixels_in_word (pixels_in_word)
    ) fetch_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .cfg         (cfg),
        .conv_ready  (conv_ready),
        .frame_done  (frame_done),
        .rd_req      (rd_req),
        .fill_cmd    (fill_cmd),
        .fill_strobe (fill_strobe),
        .busy        (busy)
    );

    row_regs #(
        .pixels_in_word (pixels_in_word),
        .shift_regs_num (shift_regs_num)
    ) regs_i (
        .clk         (clk),
        .reset       (reset),
        .fill_cmd    (fill_cmd),
        .fill_strobe (fill_strobe),
        .rd_pixels   (rd_pixels),
        .row_bank_1  (row_bank_1),
        .row_bank_2  (row_bank_2),
        .row_bank_3  (row_bank_3),
        .shift_start (shift_start),
        .row_tag     (row_tag)
    );

    window_conv #(
        .pixels_in_word (pixels_in_word),
        .shift_regs_num (shift_regs_num)
    ) conv_i (
        .clk          (clk),
        .reset        (reset),
        .kernel       (kernel),
        .row_bank_1   (row_bank_1),
        .row_bank_2   (row_bank_2),
        .row_bank_3   (row_bank_3),
        .shift_start  (shift_start),
        .row_tag      (row_tag),
        .result       (result),
        .result_valid (result_valid),
        .frame_done   (frame_done),
        .conv_ready   (conv_ready)
    );

endmodule

`default_nettype wire

// File: window_conv.sv
`default_nettype none

module window_conv #(
    parameter int pixels_in_word = 32,
    parameter int shift_regs_num = 34
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  conv_pkg::kernel_t                      kernel,
    input  conv_pkg::pixel_t [shift_regs_num-1:0]  row_bank_1,
    input  conv_pkg::pixel_t [shift_regs_num-1:0]  row_bank_2,
    input  conv_pkg::pixel_t [shift_regs_num-1:0]  row_bank_3,
    input  logic                                   shift_start,
    input  conv_pkg::row_tag_t                     row_tag,
    output conv_pkg::conv_result_t                 result,
    output logic                                   result_valid,
    output logic                                   frame_done,
    output logic                                   conv_ready
);
    import conv_pkg::*;

    localparam logic [col_w-1:0] max_cols = col_w'(pixels_in_word);

    pixel_t [2:0][shift_regs_num-1:0] work_q;
    pixel_t [2:0][shift_regs_num-1:0] src;
    pixel_t [2:0][2:0]                win;
    logic [row_w-1:0]                 row_q;
    logic                             last_q;
    logic [col_w-1:0]                 col_q;
    logic [col_w-1:0]                 left;
    logic [col_w-1:0]                 row_count;
    logic                             step;
    acc_t                             win_sum;

    function automatic acc_t mac3x3(input pixel_t [2:0][2:0] w, input kernel_t k);
        acc_t              acc;
        logic signed [16:0] prod;
        acc = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                prod = $signed({1'b0, w[r][c]}) * $signed(k[r*3+c]);
                acc  = acc + acc_t'(prod);
            end
        end
        return acc;
    endfunction

    //////////////////////////////////////////////////
    // window source
    //////////////////////////////////////////////////

    // first column straight from the banks, later ones from the copy
    always_comb begin
        src = shift_start ? {row_bank_3, row_bank_2, row_bank_1} : work_q;
        for (int r = 0; r < 3; r++) begin
            win[r] = src[r][2:0];
        end
    end

    assign win_sum   = mac3x3(win, kernel);
    assign step      = shift_start || (left != '0);
    assign row_count = (row_tag.col_count > max_cols) ? max_cols : row_tag.col_count;

    // idle, or the row tail is short enough for the next load
    assign conv_ready = (left <= col_w'(2));

    //////////////////////////////////////////////////
    // column sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            frame_done   <= 1'b0;
            left         <= '0;
        end else if (shift_start) begin
            result_valid <= 1'b1;
            frame_done   <= row_tag.last && (row_count == col_w'(1));
            left         <= row_count - 1'b1;
        end else if (left != '0) begin
            result_valid <= 1'b1;
            frame_done   <= last_q && (left == col_w'(1));
            left         <= left - 1'b1;
        end else begin
            result_valid <= 1'b0;
            frame_done   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_start) begin
            row_q  <= row_tag.row;
            last_q <= row_tag.last;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            for (int r = 0; r < 3; r++) begin
                work_q[r] <= {pixel_t'(0), src[r][shift_regs_num-1:1]};
            end
            result.row <= shift_start ? row_tag.row : row_q;
            result.col <= shift_start ? '0 : col_q;
            result.sum <= win_sum;
            col_q      <= shift_start ? col_w'(1) : col_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: row_regs.sv
`default_nettype none

module row_regs #(
    parameter int pixels_in_word = 32,
    parameter int shift_regs_num = 34
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  conv_pkg::fill_cmd_t                           fill_cmd,
    input  logic                                          fill_strobe,
    input  conv_pkg::pixel_t [2:0][pixels_in_word-1:0]    rd_pixels,
    output conv_pkg::pixel_t [shift_regs_num-1:0]         row_bank_1,
    output conv_pkg::pixel_t [shift_regs_num-1:0]         row_bank_2,
    output conv_pkg::pixel_t [shift_regs_num-1:0]         row_bank_3,
    output logic                                          shift_start,
    output conv_pkg::row_tag_t                            row_tag
);
    import conv_pkg::*;

    localparam int bank_bits = shift_regs_num * pixel_w;

    fill_cmd_t                          cmd_q;
    logic                               strobe_q;
    logic [shift_regs_num-1:0]          in_pix;
    logic [2:0][shift_regs_num-1:0]     load_op;
    pixel_t [2:0][shift_regs_num-1:0]   fill;
    pixel_t [2:0][shift_regs_num-1:0]   bank_q;

    //////////////////////////////////////////////////
    // command stage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= fill_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_strobe) begin
            cmd_q <= fill_cmd;
        end
    end

    //////////////////////////////////////////////////
    // position masks
    //////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < shift_regs_num; p++) begin
            in_pix[p] = (p >= int'(cmd_q.reg_start_idx)) && (p <= int'(cmd_q.reg_end_idx));
        end
    end

    // word pixel 0 lands on reg_start_idx, pads read as zero
    always_comb begin
        logic [bank_bits-1:0] word_ext;
        logic [bank_bits-1:0] word_sh;
        for (int r = 0; r < 3; r++) begin
            word_ext = bank_bits'(rd_pixels[r]);
            word_sh  = word_ext << (cmd_q.reg_start_idx * pixel_w);
            for (int p = 0; p < shift_regs_num; p++) begin
                load_op[r][p] = cmd_q.row_valid[r] && in_pix[p];
                fill[r][p]    = pixel_t'(word_sh[p*pixel_w +: pixel_w]);
            end
        end
    end

    //////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////

    // memory word arrives the cycle after the command
    always_ff @(posedge clk) begin
        if (strobe_q) begin
            for (int r = 0; r < 3; r++) begin
                for (int p = 0; p < shift_regs_num; p++) begin
                    bank_q[r][p] <= load_op[r][p] ? fill[r][p] : '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_start <= 1'b0;
        end else begin
            shift_start <= strobe_q;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe_q) begin
            row_tag <= cmd_q.tag;
        end
    end

    assign row_bank_1 = bank_q[0];
    assign row_bank_2 = bank_q[1];
    assign row_bank_3 = bank_q[2];

endmodule

`default_nettype wire

// File: row_fetcher.sv
`default_nettype none

module row_fetcher #(
    parameter int pixels_in_word = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  conv_pkg::frame_cfg_t  cfg,
    input  logic                  conv_ready,
    input  logic                  frame_done,
    output conv_pkg::mem_req_t    rd_req,
    output conv_pkg::fill_cmd_t   fill_cmd,
    output logic                  fill_strobe,
    output logic                  busy
);
    import conv_pkg::*;

    localparam logic [col_w-1:0] max_width = col_w'(pixels_in_word);

    logic [col_w-1:0] width_q;
    logic [row_w-1:0] height_q;
    logic [row_w-1:0] row_q;
    logic             issuing;
    logic [1:0]       hold;
    logic             accept;
    logic             issue;
    logic             last_row;

    assign accept   = start && !busy;
    assign last_row = (row_q == height_q - 1'b1);

    // hold covers the two cycles before the convolver sees the row
    assign issue       = issuing && (hold == 2'd0) && conv_ready;
    assign fill_strobe = issue;

    //////////////////////////////////////////////////
    // frame control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            issuing <= 1'b0;
            hold    <= 2'd0;
        end else begin
            if (accept) begin
                busy    <= 1'b1;
                issuing <= 1'b1;
            end else begin
                if (frame_done) begin
                    busy <= 1'b0;
                end
                if (issue && last_row) begin
                    issuing <= 1'b0;
                end
            end

            if (issue) begin
                hold <= 2'd2;
            end else if (hold != 2'd0) begin
                hold <= hold - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            width_q  <= (cfg.img_width > max_width) ? max_width : cfg.img_width;
            height_q <= cfg.img_height;
            row_q    <= '0;
        end else if (issue) begin
            row_q <= row_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // read request and fill command
    //////////////////////////////////////////////////

    always_comb begin
        rd_req             = '0;
        rd_req.en          = issue;
        rd_req.row_addr[0] = row_q - 1'b1;
        rd_req.row_addr[1] = row_q;
        rd_req.row_addr[2] = row_q + 1'b1;

        fill_cmd               = '0;
        fill_cmd.west_pad      = 4'd1;
        fill_cmd.east_pad      = 4'd1;
        fill_cmd.reg_start_idx = 16'd1;
        fill_cmd.reg_end_idx   = 16'(width_q);
        // rows off the top or bottom edge load as zeros
        fill_cmd.row_valid     = {!last_row, 1'b1, row_q != '0};
        fill_cmd.tag.row       = row_q;
        fill_cmd.tag.col_count = width_q;
        fill_cmd.tag.last      = last_row;
    end

endmodule

`default_nettype wire

// File: conv_pkg.sv
`default_nettype none

package conv_pkg;

    //////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////

    localparam int pixel_w  = 8;
    localparam int weight_w = 8;
    localparam int acc_w    = 20;
    localparam int row_w    = 16;
    localparam int col_w    = 6;

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////

    typedef logic [pixel_w-1:0] pixel_t;

    typedef logic signed [weight_w-1:0] weight_t;

    // element r*3+c is kernel row r, column c; element 0 is top left
    typedef weight_t [8:0] kernel_t;

    // nine products of 255 by 127 still fit
    typedef logic signed [acc_w-1:0] acc_t;

    //////////////////////////////////////////////////
    // control types
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [col_w-1:0] img_width;
        logic [row_w-1:0] img_height;
    } frame_cfg_t;

    // row_addr[0] above, [1] centre, [2] below
    typedef struct packed {
        logic                  en;
        logic [2:0][row_w-1:0] row_addr;
    } mem_req_t;

    typedef struct packed {
        logic [row_w-1:0] row;
        logic [col_w-1:0] col_count;
        logic             last;
    } row_tag_t;

    typedef struct packed {
        logic [3:0]       west_pad;
        logic [3:0]       east_pad;
        logic [15:0]      reg_start_idx;
        logic [15:0]      reg_end_idx;
        logic [2:0]       row_valid;
        row_tag_t         tag;
    } fill_cmd_t;

    typedef struct packed {
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
        acc_t             sum;
    } conv_result_t;

endpackage

`default_nettype wire
